/* rtl/mem_bus_pkg.sv */
package mem_bus_pkg;

  // sram word and strobe geometry
  localparam int data_w = 256;        // one 32-byte word
  localparam int strb_w = data_w / 8; // one strobe per byte
  localparam int id_w   = 6;
  localparam int len_w  = 2;          // beats minus one, 1..4 beats
  localparam int addr_w = 8;          // word index, not bytes

  // arbiter peer slots
  localparam int n_peer  = 3;
  localparam int peer_wr = 0;
  localparam int peer_rd = 1;
  localparam int peer_lk = 2;

  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [addr_w-1:0] addr;
    logic [len_w-1:0]  len;
  } aw_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } w_t;

  typedef struct packed {
    logic [id_w-1:0] id; // bresp is always okay
  } b_t;

  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [addr_w-1:0] addr;
    logic [len_w-1:0]  len;
  } ar_t;

  typedef struct packed {
    logic [id_w-1:0]   id;
    logic [data_w-1:0] data;
    logic              last;
  } r_t;

  // one sram access as seen by the arbiter
  typedef struct packed {
    logic              we;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] be;
  } mem_req_t;

endpackage

/* rtl/hawk_tbl_pkg.sv */
package hawk_tbl_pkg;

  localparam int idx_w        = 10; // entry index width
  localparam int att_per_word = 4;  // 64-bit att entries
  localparam int lst_per_word = 2;  // 128-bit list entries

  // address translation table entry
  typedef struct packed {
    logic [6:0]  zpd_cnt;
    logic [54:0] way;
    logic [1:0]  sts;
  } att_entry_t;

  // free list entry, doubly linked
  typedef struct packed {
    logic [13:0] rsvd;
    logic [49:0] way;
    logic [31:0] prev;
    logic [31:0] next;
  } lst_entry_t;

  // one unswapped word, entry 0 in the low bits
  typedef union packed {
    att_entry_t [att_per_word-1:0] att;
    lst_entry_t [lst_per_word-1:0] lst;
  } tbl_word_u;

  typedef enum logic {
    tbl_att,
    tbl_list
  } tbl_kind_e;

  typedef struct packed {
    tbl_kind_e        kind;
    logic [idx_w-1:0] idx;
  } lookup_req_t;

  // only the member matching kind carries data, the other is zero
  typedef struct packed {
    tbl_kind_e  kind;
    att_entry_t att;
    lst_entry_t lst;
  } lookup_rsp_t;

endpackage

/* rtl/line_ram.sv */
`timescale 1ns/1ps

module line_ram #(
  parameter int depth_w = 8
) (
  input  logic                            clk,
  input  logic                            en,
  input  logic                            we,
  input  logic [depth_w-1:0]              addr,
  input  logic [mem_bus_pkg::data_w-1:0]  wdata,
  input  logic [mem_bus_pkg::strb_w-1:0]  be,
  output logic [mem_bus_pkg::data_w-1:0]  rdata
);

  logic [mem_bus_pkg::data_w-1:0] mem [2**depth_w]; // one word per index

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        for (int i = 0; i < mem_bus_pkg::strb_w; i++) begin
          if (be[i]) mem[addr][8*i +: 8] <= wdata[8*i +: 8]; // byte lanes
        end
      end else begin
        rdata <= mem[addr]; // valid next cycle
      end
    end
  end

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int addr_w = mem_bus_pkg::addr_w
) (
  input  logic                                              clk,
  input  logic                                              arst_n,
  input  mem_bus_pkg::mem_req_t [mem_bus_pkg::n_peer-1:0]   req,
  input  logic [mem_bus_pkg::n_peer-1:0]                    req_valid,
  output logic [mem_bus_pkg::n_peer-1:0]                    gnt,
  output logic [mem_bus_pkg::data_w-1:0]                    rdata,
  output logic [mem_bus_pkg::n_peer-1:0]                    rdata_valid
);

  localparam int n_peer = mem_bus_pkg::n_peer;
  localparam int sel_w  = $clog2(n_peer);

  logic [sel_w-1:0] last_q;    // previous winner
  logic [sel_w-1:0] sel;       // this cycle's winner
  logic             any;
  logic [sel_w-1:0] rd_peer_q; // who owns the returning read
  logic             rd_pend_q;

  // search starts one past the last winner
  always_comb begin
    int cand;
    sel = last_q;
    any = 1'b0;
    for (int i = 1; i <= n_peer; i++) begin
      cand = (int'(last_q) + i) % n_peer;
      if (!any && req_valid[cand]) begin
        any = 1'b1;
        sel = sel_w'(cand);
      end
    end
  end

  always_comb begin
    gnt = '0;
    if (any) gnt[sel] = 1'b1; // same-cycle grant
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_q    <= sel_w'(n_peer - 1); // peer 0 first after reset
      rd_peer_q <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= any & ~req[sel].we; // only reads return data
      if (any) begin
        last_q    <= sel;
        rd_peer_q <= sel;
      end
    end
  end

  always_comb begin
    rdata_valid = '0;
    if (rd_pend_q) rdata_valid[rd_peer_q] = 1'b1; // steer to requester only
  end

  line_ram #(
    .depth_w (addr_w)
  ) line_ram_i (
    .clk   (clk),
    .en    (any),
    .we    (req[sel].we),
    .addr  (addr_w'(req[sel].addr)),
    .wdata (req[sel].wdata),
    .be    (req[sel].be),
    .rdata (rdata)
  );

endmodule

/* rtl/axi_wr_engine.sv */
`timescale 1ns/1ps

module axi_wr_engine #(
  parameter int addr_w = mem_bus_pkg::addr_w
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  mem_bus_pkg::aw_t      aw,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  mem_bus_pkg::w_t       w,
  input  logic                  w_valid,
  output logic                  w_ready,
  output mem_bus_pkg::b_t       b,
  output logic                  b_valid,
  input  logic                  b_ready,
  output mem_bus_pkg::mem_req_t mreq,
  output logic                  mreq_valid,
  input  logic                  gnt
);

  localparam int bus_aw = mem_bus_pkg::addr_w;

  typedef enum logic [1:0] {
    st_idle,
    st_data,
    st_resp
  } state_e;

  state_e                         state_q;
  logic [mem_bus_pkg::id_w-1:0]   id_q;
  logic [addr_w-1:0]              base_q;
  logic [mem_bus_pkg::len_w-1:0]  len_q;
  logic [mem_bus_pkg::len_w-1:0]  beat_q; // beats stored so far
  logic                           beat_fire;

  assign aw_ready   = (state_q == st_idle);
  assign mreq_valid = (state_q == st_data) & w_valid;
  assign w_ready    = gnt;              // beat stalls while others own the ram
  assign beat_fire  = w_valid & gnt;
  assign b_valid    = (state_q == st_resp);
  assign b.id       = id_q;

  // beat goes straight to the ram, wlast itself is not used here
  always_comb begin
    mreq.we    = 1'b1;
    mreq.addr  = bus_aw'(base_q + addr_w'(beat_q));
    mreq.wdata = w.data;
    mreq.be    = w.strb;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
      beat_q  <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (aw_valid) begin
            state_q <= st_data;
            beat_q  <= '0;
          end
        end
        st_data: begin
          if (beat_fire) begin
            beat_q <= beat_q + 1'b1;
            if (beat_q == len_q) state_q <= st_resp; // counted, not wlast
          end
        end
        st_resp: begin
          if (b_ready) state_q <= st_idle;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) begin
      id_q   <= aw.id;
      base_q <= addr_w'(aw.addr);
      len_q  <= aw.len;
    end
  end

endmodule

/* rtl/axi_rd_engine.sv */
`timescale 1ns/1ps

module axi_rd_engine #(
  parameter int addr_w = mem_bus_pkg::addr_w
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  mem_bus_pkg::ar_t                ar,
  input  logic                            ar_valid,
  output logic                            ar_ready,
  output mem_bus_pkg::r_t                 r,
  output logic                            r_valid,
  input  logic                            r_ready,
  output mem_bus_pkg::mem_req_t           mreq,
  output logic                            mreq_valid,
  input  logic                            gnt,
  input  logic [mem_bus_pkg::data_w-1:0]  rdata,
  input  logic                            rdata_valid
);

  localparam int bus_aw = mem_bus_pkg::addr_w;
  localparam int len_w  = mem_bus_pkg::len_w;

  logic                          busy_q;
  logic [mem_bus_pkg::id_w-1:0]  id_q;
  logic [addr_w-1:0]             base_q;
  logic [len_w-1:0]              len_q;
  logic [len_w:0]                iss_q;  // fetches granted, up to 4
  logic [len_w-1:0]              ret_q;  // beats returned
  logic [1:0]                    fly_q;  // fetches in flight
  logic [1:0]                    occ_q;  // buffer fill
  mem_bus_pkg::r_t               buf_q [2];
  logic                          wr_ptr_q;
  logic                          rd_ptr_q;
  logic                          issue_ok;
  logic                          issue;
  logic                          push;
  logic                          pop;

  assign ar_ready = ~busy_q;

  // credits: in flight plus buffered never exceeds two slots
  assign issue_ok = busy_q && (iss_q <= {1'b0, len_q})
                    && (({1'b0, fly_q} + {1'b0, occ_q}) < 3'd2);
  assign mreq_valid = issue_ok;
  assign issue      = issue_ok & gnt;
  assign push       = rdata_valid;
  assign pop        = r_valid & r_ready;

  assign r_valid = (occ_q != 2'd0);
  assign r       = buf_q[rd_ptr_q];

  always_comb begin
    mreq.we    = 1'b0;
    mreq.addr  = bus_aw'(base_q + addr_w'(iss_q[len_w-1:0])); // consecutive words
    mreq.wdata = '0;
    mreq.be    = '0;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q   <= 1'b0;
      iss_q    <= '0;
      ret_q    <= '0;
      fly_q    <= '0;
      occ_q    <= '0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (ar_valid && ar_ready) begin
        busy_q <= 1'b1;
        iss_q  <= '0;
        ret_q  <= '0;
      end else if (pop && r.last) begin
        busy_q <= 1'b0; // burst drained
      end
      if (issue) iss_q <= iss_q + 1'b1;
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
        ret_q    <= ret_q + 1'b1;
      end
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      fly_q <= fly_q + 2'(issue) - 2'(push);
      occ_q <= occ_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (ar_valid && ar_ready) begin
      id_q   <= ar.id;
      base_q <= addr_w'(ar.addr);
      len_q  <= ar.len;
    end
    if (push) begin
      buf_q[wr_ptr_q] <= '{id: id_q, data: rdata, last: (ret_q == len_q)}; // tag last
    end
  end

endmodule

/* rtl/entry_lookup.sv */
`timescale 1ns/1ps

module entry_lookup #(
  parameter int addr_w    = mem_bus_pkg::addr_w,
  parameter int att_base  = 64,
  parameter int list_base = 128
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  hawk_tbl_pkg::lookup_req_t       req,
  input  logic                            req_valid,
  output logic                            req_ready,
  output hawk_tbl_pkg::lookup_rsp_t       rsp,
  output logic                            rsp_valid,
  input  logic                            rsp_ready,
  output mem_bus_pkg::mem_req_t           mreq,
  output logic                            mreq_valid,
  input  logic                            gnt,
  input  logic [mem_bus_pkg::data_w-1:0]  rdata,
  input  logic                            rdata_valid
);

  localparam int bus_aw = mem_bus_pkg::addr_w;

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_wait,
    st_resp
  } state_e;

  state_e                          state_q;
  hawk_tbl_pkg::lookup_req_t       req_q;
  hawk_tbl_pkg::lookup_rsp_t       rsp_q;
  logic [addr_w-1:0]               word_addr;
  logic [mem_bus_pkg::data_w-1:0]  unswap;
  hawk_tbl_pkg::tbl_word_u         word_u;

  assign req_ready  = (state_q == st_idle);
  assign mreq_valid = (state_q == st_fetch);
  assign rsp_valid  = (state_q == st_resp);
  assign rsp        = rsp_q;

  // four att entries or two list entries per word
  always_comb begin
    if (req_q.kind == hawk_tbl_pkg::tbl_att) begin
      word_addr = addr_w'(att_base) + addr_w'(req_q.idx >> 2);
    end else begin
      word_addr = addr_w'(list_base) + addr_w'(req_q.idx >> 1);
    end
    mreq.we    = 1'b0;
    mreq.addr  = bus_aw'(word_addr);
    mreq.wdata = '0;
    mreq.be    = '0;
  end

  // stored big endian per 8-byte lane
  always_comb begin
    for (int l = 0; l < 4; l++) begin
      for (int j = 0; j < 8; j++) begin
        unswap[64*l + 8*j +: 8] = rdata[64*l + 8*(7-j) +: 8];
      end
    end
  end

  assign word_u = unswap;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle:  if (req_valid)   state_q <= st_fetch;
        st_fetch: if (gnt)         state_q <= st_wait;
        st_wait:  if (rdata_valid) state_q <= st_resp;
        st_resp:  if (rsp_ready)   state_q <= st_idle;
        default:  state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) req_q <= req;
    if ((state_q == st_wait) && rdata_valid) begin
      rsp_q.kind <= req_q.kind;
      rsp_q.att  <= '0; // unused member stays zero
      rsp_q.lst  <= '0;
      if (req_q.kind == hawk_tbl_pkg::tbl_att) begin
        rsp_q.att <= word_u.att[req_q.idx[1:0]];
      end else begin
        rsp_q.lst <= word_u.lst[req_q.idx[0]];
      end
    end
  end

endmodule

/* rtl/hawk_mem_top.sv */
`timescale 1ns/1ps

module hawk_mem_top #(
  parameter int addr_w    = mem_bus_pkg::addr_w,
  parameter int att_base  = 64,
  parameter int list_base = 128
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  mem_bus_pkg::aw_t           aw,
  input  logic                       aw_valid,
  output logic                       aw_ready,
  input  mem_bus_pkg::w_t            w,
  input  logic                       w_valid,
  output logic                       w_ready,
  output mem_bus_pkg::b_t            b,
  output logic                       b_valid,
  input  logic                       b_ready,
  input  mem_bus_pkg::ar_t           ar,
  input  logic                       ar_valid,
  output logic                       ar_ready,
  output mem_bus_pkg::r_t            r,
  output logic                       r_valid,
  input  logic                       r_ready,
  input  hawk_tbl_pkg::lookup_req_t  lookup_req,
  input  logic                       lookup_req_valid,
  output logic                       lookup_req_ready,
  output hawk_tbl_pkg::lookup_rsp_t  lookup_rsp,
  output logic                       lookup_rsp_valid,
  input  logic                       lookup_rsp_ready
);

  localparam int n_peer = mem_bus_pkg::n_peer;
  localparam int wr     = mem_bus_pkg::peer_wr;
  localparam int rd     = mem_bus_pkg::peer_rd;
  localparam int lk     = mem_bus_pkg::peer_lk;

  mem_bus_pkg::mem_req_t [n_peer-1:0] req;
  logic [n_peer-1:0]                  req_valid;
  logic [n_peer-1:0]                  gnt;
  logic [n_peer-1:0]                  rdata_valid;
  logic [mem_bus_pkg::data_w-1:0]     rdata; // shared, qualified per peer

  axi_wr_engine #(
    .addr_w (addr_w)
  ) axi_wr_engine_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .aw         (aw),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .w          (w),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .b          (b),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .mreq       (req[wr]),
    .mreq_valid (req_valid[wr]),
    .gnt        (gnt[wr])
  );

  axi_rd_engine #(
    .addr_w (addr_w)
  ) axi_rd_engine_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .ar          (ar),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .r           (r),
    .r_valid     (r_valid),
    .r_ready     (r_ready),
    .mreq        (req[rd]),
    .mreq_valid  (req_valid[rd]),
    .gnt         (gnt[rd]),
    .rdata       (rdata),
    .rdata_valid (rdata_valid[rd])
  );

  entry_lookup #(
    .addr_w    (addr_w),
    .att_base  (att_base),
    .list_base (list_base)
  ) entry_lookup_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .req         (lookup_req),
    .req_valid   (lookup_req_valid),
    .req_ready   (lookup_req_ready),
    .rsp         (lookup_rsp),
    .rsp_valid   (lookup_rsp_valid),
    .rsp_ready   (lookup_rsp_ready),
    .mreq        (req[lk]),
    .mreq_valid  (req_valid[lk]),
    .gnt         (gnt[lk]),
    .rdata       (rdata),
    .rdata_valid (rdata_valid[lk])
  );

  mem_arbiter #(
    .addr_w (addr_w)
  ) mem_arbiter_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .req         (req),
    .req_valid   (req_valid),
    .gnt         (gnt),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

endmodule

/* sim/hawk_mem_sva.sv */
`timescale 1ns/1ps

module hawk_mem_sva (
  input logic                      clk,
  input logic                      arst_n,
  input logic                      aw_ready,
  input mem_bus_pkg::w_t           w,
  input logic                      w_valid,
  input logic                      w_ready,
  input mem_bus_pkg::b_t           b,
  input logic                      b_valid,
  input logic                      b_ready,
  input logic                      ar_ready,
  input mem_bus_pkg::r_t           r,
  input logic                      r_valid,
  input logic                      r_ready,
  input hawk_tbl_pkg::lookup_rsp_t lookup_rsp,
  input logic                      lookup_rsp_valid,
  input logic                      lookup_rsp_ready
);

  int fail_cnt = 0; // failed assertions so far

  // responses hold until taken
  b_hold: assert property (@(posedge clk) disable iff (!arst_n)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else begin
      $error("b dropped or changed before bready");
      fail_cnt++;
    end

  r_hold: assert property (@(posedge clk) disable iff (!arst_n)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else begin
      $error("r dropped or changed before rready");
      fail_cnt++;
    end

  lk_hold: assert property (@(posedge clk) disable iff (!arst_n)
    lookup_rsp_valid && !lookup_rsp_ready |=> lookup_rsp_valid && $stable(lookup_rsp))
    else begin
      $error("lookup response dropped or changed before ready");
      fail_cnt++;
    end

  // bvalid right after the beat flagged last
  b_after_last: assert property (@(posedge clk) disable iff (!arst_n)
    w_valid && w_ready && w.last |=> b_valid)
    else begin
      $error("no write response after wlast");
      fail_cnt++;
    end

  // write port free again the cycle after the response
  b_then_idle: assert property (@(posedge clk) disable iff (!arst_n)
    b_valid && b_ready |=> aw_ready)
    else begin
      $error("write port still busy after the write response");
      fail_cnt++;
    end

  r_last_free: assert property (@(posedge clk) disable iff (!arst_n)
    r_valid && r_ready && r.last |=> ar_ready)
    else begin
      $error("read port still busy after rlast");
      fail_cnt++;
    end

endmodule

/* sim/hawk_mem_tb.sv */
`timescale 1ns/1ps

module hawk_mem_tb;

  localparam int att_base  = 64;
  localparam int list_base = 128;
  localparam int txn_max   = 150; // bursts and lookups below rounded up
  localparam int txn_cyc   = 40;  // worst burst under back-pressure
  localparam int timeout_cycles = txn_max * txn_cyc;

  logic                      clk = 1'b0;
  logic                      arst_n;
  mem_bus_pkg::aw_t          aw;
  logic                      aw_valid;
  logic                      aw_ready;
  mem_bus_pkg::w_t           w;
  logic                      w_valid;
  logic                      w_ready;
  mem_bus_pkg::b_t           b;
  logic                      b_valid;
  logic                      b_ready = 1'b0;
  mem_bus_pkg::ar_t          ar;
  logic                      ar_valid;
  logic                      ar_ready;
  mem_bus_pkg::r_t           r;
  logic                      r_valid;
  logic                      r_ready = 1'b0;
  hawk_tbl_pkg::lookup_req_t lookup_req;
  logic                      lookup_req_valid;
  logic                      lookup_req_ready;
  hawk_tbl_pkg::lookup_rsp_t lookup_rsp;
  logic                      lookup_rsp_valid;
  logic                      lookup_rsp_ready = 1'b0;

  integer seed   = 9;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  logic   bp_en  = 1'b0; // random bready, rready and lookup ready

  logic [255:0]              shadow [256]; // expected ram contents
  logic [5:0]                bid_q [$];    // awid per open write
  mem_bus_pkg::ar_t          ar_q [$];     // open read bursts
  hawk_tbl_pkg::lookup_req_t lk_q [$];     // open lookups
  logic [7:0]                wbase;
  logic [1:0]                wbeat;
  logic [1:0]                rbeat;

  hawk_mem_top #(
    .att_base  (att_base),
    .list_base (list_base)
  ) hawk_mem_top_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .aw               (aw),
    .aw_valid         (aw_valid),
    .aw_ready         (aw_ready),
    .w                (w),
    .w_valid          (w_valid),
    .w_ready          (w_ready),
    .b                (b),
    .b_valid          (b_valid),
    .b_ready          (b_ready),
    .ar               (ar),
    .ar_valid         (ar_valid),
    .ar_ready         (ar_ready),
    .r                (r),
    .r_valid          (r_valid),
    .r_ready          (r_ready),
    .lookup_req       (lookup_req),
    .lookup_req_valid (lookup_req_valid),
    .lookup_req_ready (lookup_req_ready),
    .lookup_rsp       (lookup_rsp),
    .lookup_rsp_valid (lookup_rsp_valid),
    .lookup_rsp_ready (lookup_rsp_ready)
  );

  bind hawk_mem_top hawk_mem_sva hawk_mem_sva_i (.*);

  always #2 clk = ~clk; // 4 ns period

  function automatic int rnd(input int m);
    return {$random(seed)} % m; // non-negative
  endfunction

  function automatic logic [5:0] rand_id();
    return 6'($random(seed));
  endfunction

  // expected word of one read beat
  function automatic logic [255:0] ref_beat(input logic [7:0] base, input logic [1:0] beat);
    return shadow[base + 8'(beat)];
  endfunction

  // locate the word, reverse each 8-byte lane and cut out the entry
  function automatic hawk_tbl_pkg::lookup_rsp_t ref_entry(input hawk_tbl_pkg::lookup_req_t q);
    logic [7:0]                wa;
    logic [255:0]              word;
    logic [255:0]              plain;
    logic [63:0]               a;
    logic [127:0]              l;
    hawk_tbl_pkg::lookup_rsp_t e;
    if (q.kind == hawk_tbl_pkg::tbl_att) begin
      wa = 8'(att_base + int'(q.idx) / 4); // four per word
    end else begin
      wa = 8'(list_base + int'(q.idx) / 2); // two per word
    end
    word = shadow[wa];
    for (int ln = 0; ln < 4; ln++) begin
      plain[64*ln +: 64] = {<<8{word[64*ln +: 64]}}; // byte order of one lane flipped
    end
    e = '0;
    e.kind = q.kind;
    if (q.kind == hawk_tbl_pkg::tbl_att) begin
      a = plain[64*int'(q.idx[1:0]) +: 64];
      e.att.zpd_cnt = a[63:57];
      e.att.way     = a[56:2];
      e.att.sts     = a[1:0];
    end else begin
      l = plain[128*int'(q.idx[0]) +: 128];
      e.lst.rsvd = l[127:114];
      e.lst.way  = l[113:64];
      e.lst.prev = l[63:32];
      e.lst.next = l[31:0];
    end
    return e;
  endfunction

  // sends one aw and its beats without waiting for b
  task automatic write_burst(input logic [7:0] addr, input int beats,
                             input logic [5:0] id, input bit partial);
    logic [255:0] d;
    logic [31:0]  s;
    @(negedge clk);
    aw_valid = 1'b1;
    aw.id    = id;
    aw.addr  = addr;
    aw.len   = 2'(beats - 1);
    #1; // ready settled well before the edge
    while (!aw_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    aw_valid = 1'b0;
    for (int k = 0; k < beats; k++) begin
      for (int i = 0; i < 8; i++) d[32*i +: 32] = $random(seed);
      s = partial ? 32'($random(seed)) : '1;
      w_valid = 1'b1;
      w.data  = d;
      w.strb  = s;
      w.last  = (k == beats - 1);
      #1;
      while (!w_ready) begin // stalls while other peers own the ram
        @(negedge clk);
        #1;
      end
      @(negedge clk);
    end
    w_valid = 1'b0;
  endtask

  task automatic read_burst(input logic [7:0] addr, input int beats, input logic [5:0] id);
    @(negedge clk);
    ar_valid = 1'b1;
    ar.id    = id;
    ar.addr  = addr;
    ar.len   = 2'(beats - 1);
    #1;
    while (!ar_ready) begin // busy until previous rlast
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  task automatic lookup(input hawk_tbl_pkg::tbl_kind_e kind, input int idx);
    @(negedge clk);
    lookup_req_valid = 1'b1;
    lookup_req.kind  = kind;
    lookup_req.idx   = 10'(idx);
    #1;
    while (!lookup_req_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    lookup_req_valid = 1'b0;
  endtask

  // everything answered and the write port idle again
  task automatic drain();
    while (bid_q.size() != 0 || ar_q.size() != 0 || lk_q.size() != 0 || !aw_ready) begin
      @(negedge clk);
    end
  endtask

  always @(negedge clk) begin
    if (bp_en) begin
      b_ready          = (rnd(3) != 0);
      r_ready          = (rnd(3) != 0);
      lookup_rsp_ready = (rnd(2) != 0);
    end else begin
      b_ready          = 1'b1;
      r_ready          = 1'b1;
      lookup_rsp_ready = 1'b1;
    end
  end

  // watch every handshake and compare against the shadow
  always @(posedge clk) begin
    mem_bus_pkg::ar_t          cur;
    hawk_tbl_pkg::lookup_rsp_t exp;
    logic [255:0]              exp_data;
    logic [7:0]                wa;
    if (arst_n) begin
      if (aw_valid && aw_ready) begin
        wbase = aw.addr;
        wbeat = '0;
        bid_q.push_back(aw.id);
      end
      if (w_valid && w_ready) begin
        wa = wbase + 8'(wbeat); // consecutive words
        for (int i = 0; i < 32; i++) begin
          if (w.strb[i]) shadow[wa][8*i +: 8] = w.data[8*i +: 8];
        end
        wbeat++;
      end
      if (b_valid && b_ready) begin
        checks++;
        if (bid_q.size() == 0) begin
          $display("write response at %0t with no write outstanding", $time);
          errors++;
        end else begin
          if (b.id !== bid_q[0]) begin
            $display("FAILED %0t b.id exp=%h got=%h", $time, bid_q[0], b.id);
            errors++;
          end
          void'(bid_q.pop_front());
        end
      end
      if (r_valid && r_ready) begin
        checks++;
        if (ar_q.size() == 0) begin
          $display("read beat at %0t with no read outstanding", $time);
          errors++;
        end else begin
          cur      = ar_q[0];
          exp_data = ref_beat(cur.addr, rbeat);
          if (r.data !== exp_data) begin
            $display("FAILED %0t r.data exp=%h got=%h", $time, exp_data, r.data);
            errors++;
          end
          if (r.id !== cur.id) begin
            $display("FAILED %0t r.id exp=%h got=%h", $time, cur.id, r.id);
            errors++;
          end
          if (r.last !== (rbeat == cur.len)) begin
            $display("FAILED %0t r.last exp=%b got=%b", $time, rbeat == cur.len, r.last);
            errors++;
          end
          if (rbeat == cur.len) begin
            void'(ar_q.pop_front());
            rbeat = '0;
          end else begin
            rbeat++;
          end
        end
      end
      if (ar_valid && ar_ready) begin
        ar_q.push_back(ar);
        rbeat = '0;
      end
      if (lookup_rsp_valid && lookup_rsp_ready) begin
        checks++;
        if (lk_q.size() == 0) begin
          $display("lookup response at %0t with no lookup outstanding", $time);
          errors++;
        end else begin
          exp = ref_entry(lk_q.pop_front());
          if (lookup_rsp.kind !== exp.kind) begin
            $display("FAILED %0t lookup_rsp.kind exp=%b got=%b", $time, exp.kind,
                     lookup_rsp.kind);
            errors++;
          end
          if (lookup_rsp.att !== exp.att) begin
            $display("FAILED %0t lookup_rsp.att exp=%p got=%p", $time, exp.att,
                     lookup_rsp.att);
            errors++;
          end
          if (lookup_rsp.lst !== exp.lst) begin // rsvd, way, prev, next
            $display("FAILED %0t lookup_rsp.lst exp=%p got=%p", $time, exp.lst,
                     lookup_rsp.lst);
            errors++;
          end
        end
      end
      if (lookup_req_valid && lookup_req_ready) lk_q.push_back(lookup_req);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles with transactions still open", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    logic [7:0] a;
    int         n;
    arst_n           = 1'b0;
    aw               = '0;
    aw_valid         = 1'b0;
    w                = '0;
    w_valid          = 1'b0;
    ar               = '0;
    ar_valid         = 1'b0;
    lookup_req       = '0;
    lookup_req_valid = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // full strobes of 1..4 beats packed over words 0..39
    a = '0;
    for (int k = 0; k < 16; k++) begin
      n = k % 4 + 1;
      write_burst(a, n, rand_id(), 1'b0);
      read_burst(a, n, rand_id());
      a = a + 8'(n);
    end

    // partial strobes over words already written
    for (int k = 0; k < 8; k++) begin
      n = k % 4 + 1;
      write_burst(8'(4 * k), n, rand_id(), 1'b1);
      read_burst(8'(4 * k), n, rand_id());
    end

    bp_en = 1'b1; // back-pressure from here on
    for (int k = 0; k < 8; k++) begin
      drain(); // earlier read may still hold words of the next write
      n = rnd(4) + 1;
      a = 8'(rnd(41 - n));
      write_burst(a, n, rand_id(), k[0]);
      read_burst(a, n, rand_id());
    end

    // att words and then every index in them
    write_burst(8'(att_base), 4, rand_id(), 1'b0);
    write_burst(8'(att_base + 4), 4, rand_id(), 1'b0);
    for (int i = 0; i < 32; i++) lookup(hawk_tbl_pkg::tbl_att, i);

    // same for the free list
    write_burst(8'(list_base), 4, rand_id(), 1'b0);
    write_burst(8'(list_base + 4), 4, rand_id(), 1'b0);
    for (int i = 0; i < 16; i++) lookup(hawk_tbl_pkg::tbl_list, i);

    // all three peers at once on disjoint words
    fork
      begin
        for (int k = 0; k < 8; k++) begin
          repeat (rnd(4)) @(negedge clk);
          write_burst(8'(200 + 4 * k), 4, rand_id(), 1'b0);
        end
      end
      begin
        int m;
        for (int k = 0; k < 8; k++) begin
          m = rnd(4) + 1;
          repeat (rnd(4)) @(negedge clk);
          read_burst(8'(rnd(41 - m)), m, rand_id());
        end
      end
      begin
        for (int k = 0; k < 8; k++) begin
          repeat (rnd(4)) @(negedge clk);
          if (rnd(2) == 0) lookup(hawk_tbl_pkg::tbl_att, rnd(32));
          else lookup(hawk_tbl_pkg::tbl_list, rnd(16));
        end
      end
    join
    drain();
    for (int k = 0; k < 8; k++) read_burst(8'(200 + 4 * k), 4, rand_id()); // words from fork

    drain();
    repeat (4) @(negedge clk);
    errors += hawk_mem_top_i.hawk_mem_sva_i.fail_cnt;
    $display("checks %0d  errors %0d  cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
rtl/mem_bus_pkg.sv
rtl/hawk_tbl_pkg.sv
rtl/line_ram.sv
rtl/mem_arbiter.sv
rtl/axi_wr_engine.sv
rtl/axi_rd_engine.sv
rtl/entry_lookup.sv
rtl/hawk_mem_top.sv
sim/hawk_mem_sva.sv
sim/hawk_mem_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := hawk_mem_tb
FLIST      := vlog.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
